/* flist.f */
hdl/spi_pkg.sv
hdl/spi_ifs.sv
hdl/spi_cmd_fifo.sv
hdl/spi_clk_gen.sv
hdl/spi_shift.sv
hdl/spi_ctrl.sv
hdl/spi_master.sv
tests/spi_slave_model.sv
tests/tb_spi_master.sv

/* Bender.yml */
package:
  name: spi_master

sources:
  - hdl/spi_pkg.sv
  - hdl/spi_ifs.sv
  - hdl/spi_cmd_fifo.sv
  - hdl/spi_clk_gen.sv
  - hdl/spi_shift.sv
  - hdl/spi_ctrl.sv
  - hdl/spi_master.sv
  - target: test
    files:
      - tests/spi_slave_model.sv
      - tests/tb_spi_master.sv

/* tests/tb_spi_master.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_spi_master;
  import spi_pkg::*;

  localparam logic [31:0] SEED = 32'h5673;
  localparam int TIMEOUT_CYCLES = 5000;
  localparam int NUM_REGS = 1 << ADDR_WIDTH;

  logic       clk;
  logic       rst_n;
  spi_cmd_t   cmd_in;
  logic       cmd_vld;
  logic       cmd_rdy;
  logic       sclk;
  logic       cs_n;
  logic       mosi;
  logic       miso;
  logic       read_vld;
  spi_rdata_t read_data;

  logic [31:0] lfsr;
  spi_rdata_t  shadow [NUM_REGS];
  spi_rdata_t  exp_q [$];
  int          sent_cnt = 0;
  int          done_cnt = 0;
  int          reads_sent = 0;
  int          vld_cnt = 0;
  logic        saw_full = 1'b0;

  always #10 clk = ~clk;

  spi_master #(
    .SCLK_HALF  (4),
    .FIFO_DEPTH (4)
  ) DUT (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd_in    (cmd_in),
    .cmd_vld   (cmd_vld),
    .cmd_rdy   (cmd_rdy),
    .sclk      (sclk),
    .cs_n      (cs_n),
    .mosi      (mosi),
    .miso      (miso),
    .read_vld  (read_vld),
    .read_data (read_data)
  );

  spi_slave_model u_slave (
    .rst_n (rst_n),
    .sclk  (sclk),
    .cs_n  (cs_n),
    .mosi  (mosi),
    .miso  (miso)
  );

  task automatic stop_with_failure(input string reason);
    $display("%s", reason);
    $display("Testbench failed");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] expected);
    if (got !== expected)
      stop_with_failure($sformatf("ERROR at %0t ns: %s is %h, expected %h",
                                  $time, name, got, expected));
  endtask

  // x^32 + x^22 + x^2 + x + 1, right shifting
  function automatic logic [31:0] lfsr_next(input logic [31:0] state);
    if (state[0])
      return (state >> 1) ^ 32'h8020_0003;
    return state >> 1;
  endfunction

  task automatic draw_bits(input int count, output logic [31:0] value);
    value = '0;
    for (int i = 0; i < count; i++)
    begin
      lfsr  = lfsr_next(lfsr);
      value = {value[30:0], lfsr[0]};
    end
  endtask

  function automatic spi_cmd_t make_cmd(input logic wr, input spi_addr_t addr,
                                        input spi_rdata_t data);
    return {wr, addr, data};
  endfunction

  // shadow register file, returns the byte a read must see
  function automatic spi_rdata_t expected_read(input spi_cmd_t cmd);
    spi_addr_t addr;
    addr = cmd[RW_BIT-1 -: ADDR_WIDTH];
    if (cmd[RW_BIT])
    begin
      shadow[addr] = cmd[READ_WIDTH-1:0];
      return '0;
    end
    return shadow[addr];
  endfunction

  // called right after a falling edge
  task automatic push_cmd(input spi_cmd_t cmd);
    int waited;
    waited  = 0;
    cmd_in  = cmd;
    cmd_vld = 1'b1;
    while (!cmd_rdy)
    begin
      saw_full = 1'b1;
      @(negedge clk);
      waited++;
      if (waited > TIMEOUT_CYCLES)
        stop_with_failure("timeout: cmd_rdy stayed low");
    end
    @(negedge clk); // taken on the rising edge in between
    cmd_vld = 1'b0;
    sent_cnt++;
    if (!cmd[RW_BIT])
    begin
      exp_q.push_back(expected_read(cmd));
      reads_sent++;
    end
    else
    begin
      void'(expected_read(cmd));
    end
  endtask

  task automatic wait_idle();
    int waited;
    waited = 0;
    while (done_cnt != sent_cnt)
    begin
      @(negedge clk);
      waited++;
      if (waited > TIMEOUT_CYCLES)
        stop_with_failure("timeout: transactions did not complete");
    end
    @(negedge clk); // last read_vld already compared
    check_value("cs_n", cs_n, 1'b1);
    check_value("sclk", sclk, 1'b0);
    check_value("cmd_rdy", cmd_rdy, 1'b1);
    check_value("read_vld count", vld_cnt, reads_sent);
  endtask

  always @(posedge cs_n)
  begin
    if (rst_n === 1'b1)
      done_cnt++; // end of a transaction
  end

  always @(negedge clk)
  begin
    if (rst_n && read_vld)
    begin
      vld_cnt++;
      if (exp_q.size() == 0)
        stop_with_failure("read_vld pulsed with no read outstanding");
      else
        check_value("read_data", read_data, exp_q.pop_front());
    end
  end

  always @(negedge clk)
  begin
    if (rst_n && cs_n && sclk)
      stop_with_failure("sclk is high while cs_n is high");
  end

  initial
  begin
    logic [31:0] rnd;
    clk     = 1'b0;
    rst_n   = 1'b0;
    cmd_in  = '0;
    cmd_vld = 1'b0;
    lfsr    = SEED;
    for (int i = 0; i < NUM_REGS; i++)
      shadow[i] = '0;
    repeat (10) @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);
    check_value("cs_n", cs_n, 1'b1);
    check_value("sclk", sclk, 1'b0);
    check_value("cmd_rdy", cmd_rdy, 1'b1);

    // registers read back zero after reset
    for (int a = 0; a < NUM_REGS; a++)
      push_cmd(make_cmd(1'b0, spi_addr_t'(a), '0));
    wait_idle();

    push_cmd(make_cmd(1'b1, 3'd3, 8'hA5));
    push_cmd(make_cmd(1'b1, 3'd6, 8'h3C));
    for (int a = 0; a < NUM_REGS; a++)
      push_cmd(make_cmd(1'b0, spi_addr_t'(a), '0));
    wait_idle();

    // back to back until the FIFO fills
    saw_full = 1'b0;
    for (int i = 0; i < 12; i++)
      push_cmd(make_cmd(i[0] ? 1'b0 : 1'b1, spi_addr_t'(i), spi_rdata_t'(8'h40 + i)));
    check_value("cmd_rdy dropped", saw_full, 1'b1);
    wait_idle();

    for (int i = 0; i < 200; i++)
    begin
      draw_bits(CMD_WIDTH, rnd);
      push_cmd(spi_cmd_t'(rnd));
    end
    wait_idle();

    $display("Testbench passed");
    $finish;
  end

endmodule

`default_nettype wire

/* tests/spi_slave_model.sv */
`timescale 1ns/10ps
`default_nettype none

module spi_slave_model (
  input  logic rst_n,
  input  logic sclk,
  input  logic cs_n,
  input  logic mosi,
  output logic miso
);
  import spi_pkg::*;

  localparam int NUM_REGS = 1 << ADDR_WIDTH;

  spi_rdata_t regs [NUM_REGS];
  spi_cmd_t   rx_shift;
  spi_cmd_t   word;     // shifted bits plus the one on mosi now
  spi_rdata_t tx_byte;
  logic       reading;
  int         bit_cnt;

  assign word = {rx_shift[CMD_WIDTH-2:0], mosi};

  always @(posedge sclk or posedge cs_n or negedge rst_n)
  begin
    if (!rst_n)
    begin
      for (int i = 0; i < NUM_REGS; i++)
        regs[i] <= '0;
      rx_shift <= '0;
      tx_byte  <= '0;
      reading  <= 1'b0;
      bit_cnt  <= 0;
    end
    else if (cs_n)
    begin
      reading <= 1'b0; // frame over
      bit_cnt <= 0;
    end
    else
    begin
      rx_shift <= word;
      bit_cnt  <= bit_cnt + 1;
      if (bit_cnt == CMD_WIDTH - 1)
      begin
        if (word[RW_BIT])
          regs[word[RW_BIT-1 -: ADDR_WIDTH]] <= word[READ_WIDTH-1:0];
        else
          tx_byte <= regs[word[RW_BIT-1 -: ADDR_WIDTH]];
        reading <= !word[RW_BIT];
      end
    end
  end

  // mode 0, next bit goes out after each falling edge
  always @(negedge sclk or posedge cs_n or negedge rst_n)
  begin
    if (!rst_n || cs_n)
      miso <= 1'b0;
    else if (reading && bit_cnt < CMD_WIDTH + READ_WIDTH)
      miso <= tx_byte[CMD_WIDTH + READ_WIDTH - 1 - bit_cnt]; // msb first
  end

endmodule

`default_nettype wire

/* hdl/spi_master.sv */
`timescale 1ns/10ps
`default_nettype none

module spi_master #(
  parameter int SCLK_HALF  = 4,
  parameter int FIFO_DEPTH = 4
) (
  input  logic                clk,
  input  logic                rst_n,
  input  spi_pkg::spi_cmd_t   cmd_in,
  input  logic                cmd_vld,
  output logic                cmd_rdy,
  output logic                sclk,
  output logic                cs_n,
  output logic                mosi,
  input  logic                miso,
  output logic                read_vld,
  output spi_pkg::spi_rdata_t read_data
);
  import spi_pkg::*;

  spi_cmd_t fifo_data;
  logic     fifo_vld;
  logic     fifo_rdy;

  spi_clk_if   clk_bus ();
  spi_shift_if shift_bus ();

  assign sclk = clk_bus.sclk;

  spi_cmd_fifo #(
    .FIFO_DEPTH (FIFO_DEPTH)
  ) u_fifo (
    .clk      (clk),
    .rst_n    (rst_n),
    .in_data  (cmd_in),
    .in_vld   (cmd_vld),
    .in_rdy   (cmd_rdy),
    .out_data (fifo_data),
    .out_vld  (fifo_vld),
    .out_rdy  (fifo_rdy)
  );

  spi_ctrl #(
    .SCLK_HALF (SCLK_HALF)
  ) u_ctrl (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd       (fifo_data),
    .cmd_vld   (fifo_vld),
    .cmd_rdy   (fifo_rdy),
    .clk_bus   (clk_bus.ctrl),
    .shift_bus (shift_bus.ctrl),
    .cs_n      (cs_n),
    .read_vld  (read_vld),
    .read_data (read_data)
  );

  spi_clk_gen #(
    .SCLK_HALF (SCLK_HALF)
  ) u_clk_gen (
    .clk     (clk),
    .rst_n   (rst_n),
    .clk_bus (clk_bus.gen)
  );

  spi_shift u_shift (
    .clk       (clk),
    .rst_n     (rst_n),
    .shift_bus (shift_bus.shifter),
    .miso      (miso),
    .mosi      (mosi)
  );

endmodule

`default_nettype wire

/* hdl/spi_ctrl.sv */
`timescale 1ns/10ps
`default_nettype none

module spi_ctrl #(
  parameter int SCLK_HALF = 4
) (
  input  logic                clk,
  input  logic                rst_n,
  input  spi_pkg::spi_cmd_t   cmd,
  input  logic                cmd_vld,
  output logic                cmd_rdy,
  spi_clk_if.ctrl             clk_bus,
  spi_shift_if.ctrl           shift_bus,
  output logic                cs_n,
  output logic                read_vld,
  output spi_pkg::spi_rdata_t read_data
);
  import spi_pkg::*;

  localparam int HALF_W = (SCLK_HALF > 1) ? $clog2(SCLK_HALF) : 1;
  localparam logic [HALF_W-1:0] HALF_MAX = HALF_W'(SCLK_HALF - 1);
  localparam bit_cnt_t SEND_LAST = bit_cnt_t'(CMD_WIDTH - 1);
  localparam bit_cnt_t RECV_LAST = bit_cnt_t'(CMD_WIDTH + READ_WIDTH - 1);

  spi_state_t        state;
  bit_cnt_t          bit_cnt;
  logic [HALF_W-1:0] half_cnt;
  logic              half_last;
  logic              rw_flag; // 1 for a write
  logic              sclk_en;
  logic              accept;
  logic              finish_done;

  assign cmd_rdy     = (state == IDLE);
  assign accept      = cmd_vld && cmd_rdy;
  assign half_last   = (half_cnt == HALF_MAX);
  assign finish_done = (state == FINISH) && !sclk_en && half_last;

  assign clk_bus.enable     = sclk_en;
  assign shift_bus.load     = accept;
  assign shift_bus.load_cmd = cmd;
  assign shift_bus.shift    = (state == SEND) && clk_bus.fall; // next bit after falling edge
  assign shift_bus.sample   = (state == RECV) && clk_bus.rise;

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state    <= IDLE;
      bit_cnt  <= '0;
      half_cnt <= '0;
      rw_flag  <= 1'b0;
      sclk_en  <= 1'b0;
      cs_n     <= 1'b1;
      read_vld <= 1'b0;
    end
    else
    begin
      read_vld <= 1'b0;
      case (state)
        IDLE:
        begin
          if (accept)
          begin
            rw_flag  <= cmd[RW_BIT];
            bit_cnt  <= '0;
            half_cnt <= '0;
            cs_n     <= 1'b0;
            state    <= SETUP;
          end
        end
        SETUP:
        begin
          if (half_last)
          begin
            half_cnt <= '0;
            sclk_en  <= 1'b1;
            state    <= SEND;
          end
          else
          begin
            half_cnt <= half_cnt + 1'b1; // cs_n to first edge
          end
        end
        SEND:
        begin
          if (clk_bus.rise)
          begin
            bit_cnt <= bit_cnt + bit_cnt_t'(1);
            if (bit_cnt == SEND_LAST)
              state <= rw_flag ? FINISH : RECV;
          end
        end
        RECV:
        begin
          if (clk_bus.rise)
          begin
            bit_cnt <= bit_cnt + bit_cnt_t'(1);
            if (bit_cnt == RECV_LAST)
              state <= FINISH;
          end
        end
        FINISH:
        begin
          if (sclk_en)
          begin
            if (clk_bus.fall)
              sclk_en <= 1'b0; // last falling edge seen
          end
          else if (half_last)
          begin
            half_cnt <= '0;
            cs_n     <= 1'b1;
            read_vld <= !rw_flag;
            state    <= IDLE;
          end
          else
          begin
            half_cnt <= half_cnt + 1'b1; // cs_n hold time
          end
        end
        default:
        begin
          state <= IDLE;
        end
      endcase
    end
  end

  always_ff @(posedge clk)
  begin
    if (finish_done && !rw_flag)
      read_data <= shift_bus.rx_data;
  end

  a_cs_during_clk: assert property (@(posedge clk) disable iff (!rst_n)
    clk_bus.enable |-> !cs_n);

  // only a transaction that clocked in the read byte may report one
  a_vld_after_read: assert property (@(posedge clk) disable iff (!rst_n)
    read_vld |-> (bit_cnt == bit_cnt_t'(CMD_WIDTH + READ_WIDTH)));

  // shifter was loaded with this command, its msb is the write flag
  a_load_msb: assert property (@(posedge clk) disable iff (!rst_n)
    (state == SETUP) |-> (shift_bus.tx_msb == rw_flag));

endmodule

`default_nettype wire

/* hdl/spi_shift.sv */
`timescale 1ns/10ps
`default_nettype none

module spi_shift (
  input  logic          clk,
  input  logic          rst_n,
  spi_shift_if.shifter  shift_bus,
  input  logic          miso,
  output logic          mosi
);
  import spi_pkg::*;

  spi_cmd_t   tx_reg;
  spi_rdata_t rx_reg;

  assign shift_bus.tx_msb  = tx_reg[CMD_WIDTH-1]; // msb first
  assign shift_bus.rx_data = rx_reg;
  assign mosi              = shift_bus.tx_msb;

  // transmit side, reset so mosi is defined before the first command
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      tx_reg <= '0;
    end
    else if (shift_bus.load)
    begin
      tx_reg <= shift_bus.load_cmd;
    end
    else if (shift_bus.shift)
    begin
      tx_reg <= {tx_reg[CMD_WIDTH-2:0], 1'b0};
    end
  end

  always_ff @(posedge clk)
  begin
    if (shift_bus.load)
    begin
      rx_reg <= '0;
    end
    else if (shift_bus.sample)
    begin
      rx_reg <= {rx_reg[READ_WIDTH-2:0], miso}; // fills msb first
    end
  end

endmodule

`default_nettype wire

/* hdl/spi_clk_gen.sv */
`timescale 1ns/10ps
`default_nettype none

module spi_clk_gen #(
  parameter int SCLK_HALF = 4
) (
  input  logic   clk,
  input  logic   rst_n,
  spi_clk_if.gen clk_bus
);

  localparam int CNT_W = (SCLK_HALF > 1) ? $clog2(SCLK_HALF) : 1;
  localparam logic [CNT_W-1:0] HALF_MAX = CNT_W'(SCLK_HALF - 1);

  logic [CNT_W-1:0] half_cnt;
  logic             half_done;

  assign half_done    = clk_bus.enable && (half_cnt == HALF_MAX);
  assign clk_bus.rise = half_done && !clk_bus.sclk;
  assign clk_bus.fall = half_done && clk_bus.sclk;

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      half_cnt     <= '0;
      clk_bus.sclk <= 1'b0;
    end
    else if (!clk_bus.enable)
    begin
      half_cnt     <= '0; // idle low, restart from a full half period
      clk_bus.sclk <= 1'b0;
    end
    else if (half_done)
    begin
      half_cnt     <= '0;
      clk_bus.sclk <= !clk_bus.sclk;
    end
    else
    begin
      half_cnt <= half_cnt + 1'b1;
    end
  end

  // sclk stays high for a full half period
  a_strobe_edge: assert property (@(posedge clk) disable iff (!rst_n)
    clk_bus.fall |-> $past(clk_bus.rise, SCLK_HALF));

endmodule

`default_nettype wire

/* hdl/spi_cmd_fifo.sv */
`timescale 1ns/10ps
`default_nettype none

module spi_cmd_fifo #(
  parameter int FIFO_DEPTH = 4
) (
  input  logic              clk,
  input  logic              rst_n,
  input  spi_pkg::spi_cmd_t in_data,
  input  logic              in_vld,
  output logic              in_rdy,
  output spi_pkg::spi_cmd_t out_data,
  output logic              out_vld,
  input  logic              out_rdy
);
  import spi_pkg::*;

  localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
  localparam logic [PTR_W:0] FULL_CNT = (PTR_W + 1)'(FIFO_DEPTH);

  spi_cmd_t         mem [FIFO_DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [PTR_W:0]   count;
  logic             push;
  logic             pop;

  assign in_rdy   = (count != FULL_CNT);
  assign out_vld  = (count != '0);
  assign out_data = mem[rd_ptr]; // show-ahead read
  assign push     = in_vld && in_rdy;
  assign pop      = out_vld && out_rdy;

  always_ff @(posedge clk)
  begin
    if (push)
      mem[wr_ptr] <= in_data;
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end
    else
    begin
      if (push)
        wr_ptr <= wr_ptr + 1'b1; // wraps, depth is a power of two
      if (pop)
        rd_ptr <= rd_ptr + 1'b1;
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // a command offered while full is held until the FIFO takes it
  a_no_push_full: assert property (@(posedge clk) disable iff (!rst_n)
    (in_vld && !in_rdy) |=> in_vld && $stable(in_data));

endmodule

`default_nettype wire

/* hdl/spi_ifs.sv */
`timescale 1ns/10ps
`default_nettype none

interface spi_clk_if;
  logic enable; // from controller
  logic sclk;
  logic rise;   // one clk wide, sclk going high
  logic fall;   // one clk wide, sclk going low

  modport gen (
    input  enable,
    output sclk,
    output rise,
    output fall
  );

  modport ctrl (
    output enable,
    input  rise,
    input  fall
  );
endinterface

interface spi_shift_if;
  import spi_pkg::*;

  logic       load;
  spi_cmd_t   load_cmd;
  logic       shift;
  logic       sample;
  spi_rdata_t rx_data;
  logic       tx_msb; // bit currently on mosi

  modport ctrl (
    output load,
    output load_cmd,
    output shift,
    output sample,
    input  rx_data,
    input  tx_msb
  );

  modport shifter (
    input  load,
    input  load_cmd,
    input  shift,
    input  sample,
    output rx_data,
    output tx_msb
  );
endinterface

`default_nettype wire

/* hdl/spi_pkg.sv */
`default_nettype none

package spi_pkg;

  localparam int CMD_WIDTH  = 12;
  localparam int READ_WIDTH = 8;
  localparam int ADDR_WIDTH = 3;
  localparam int RW_BIT     = 11; // 1 = write, 0 = read

  typedef logic [CMD_WIDTH-1:0]  spi_cmd_t;
  typedef logic [READ_WIDTH-1:0] spi_rdata_t;
  typedef logic [ADDR_WIDTH-1:0] spi_addr_t;

  // up to CMD_WIDTH + READ_WIDTH rise strobes per read
  typedef logic [4:0] bit_cnt_t;

  typedef enum logic [2:0] {
    IDLE,
    SETUP,
    SEND,
    RECV,
    FINISH
  } spi_state_t;

endpackage

`default_nettype wire
